//--- design/div_pkg.sv
/*
  Shared widths and types for the divide unit.
  ID_W sets the number of result bank entries and in-flight ids.
*/
`default_nettype none

package div_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Operand and result width
    localparam int XLEN = 32;
    // Instruction id width, four ids in flight
    localparam int ID_W = 2;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [ID_W-1:0] id_t;

    //////////////////////////////////////////////////////////////////////
    // Operations
    //////////////////////////////////////////////////////////////////////

    // Bit 0 set for unsigned, bit 1 set for remainder
    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,
        OP_DIVU = 2'd1,
        OP_REM  = 2'd2,
        OP_REMU = 2'd3
    } div_op_e;

    // Issued request, 69 bits
    typedef struct packed {
        data_t   rs1;
        data_t   rs2;
        div_op_e op;
        id_t     id;
        // Same operands as the previous request
        logic    reuse;
    } div_req_t;

    // Completion strobe toward writeback
    typedef struct packed {
        logic done;
        id_t  id;
    } div_wb_t;

endpackage

`default_nettype wire

//--- design/div_input_fifo.sv
/*
  Request buffer between issue and the divide unit.
  Pushing while full or popping while empty is illegal.
  data_out is valid only while valid is high.
*/
`timescale 1ns/100ps
`default_nettype none

module div_input_fifo #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  div_pkg::div_req_t data_in,
    input  logic             pop,
    output div_pkg::div_req_t data_out,
    output logic             valid,
    output logic             full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Entry storage
    div_pkg::div_req_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at the last entry for any depth
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Write port
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= data_in;
    end

    // Oldest entry sits at the read pointer
    assign data_out = mem[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(FIFO_DEPTH));

    // Issue side must respect ready
    no_push_when_full: assert property (@(posedge clk) disable iff (rst) full |-> !push)
        else $error("request pushed into a full input FIFO");

    // Unit pops only what it has seen at the head
    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) !valid |-> !pop)
        else $error("pop from an empty input FIFO");

endmodule

`default_nettype wire

//--- design/div_core.sv
/*
  Radix-2 restoring divider on unsigned operands, no early exit.
  complete pulses WIDTH+1 cycles after start; q and r hold until next start.
  WIDTH is expected to equal div_pkg::XLEN.
*/
`timescale 1ns/100ps
`default_nettype none

module div_core #(
    parameter int WIDTH = div_pkg::XLEN
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  div_pkg::data_t a,
    input  div_pkg::data_t b,
    output div_pkg::data_t q,
    output div_pkg::data_t r,
    output logic           b_zero,
    output logic           complete
);

    localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_core_state_e;

    div_core_state_e state;
    logic [CNT_W-1:0] cnt;

    // Quotient register starts out holding the dividend
    logic [WIDTH-1:0] quot;
    logic [WIDTH-1:0] prem;
    logic [WIDTH-1:0] divisor;

    logic [WIDTH:0] shifted;
    logic [WIDTH:0] diff;
    logic           fits;

    //////////////////////////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    state <= RUN;
                    cnt   <= '0;
                end
                RUN: begin
                    cnt <= cnt + 1'b1;
                    // Last of WIDTH iterations
                    if (cnt == CNT_W'(WIDTH - 1))
                        state <= DONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    // Next dividend bit enters the partial remainder
    assign shifted = {prem, quot[WIDTH-1]};
    assign diff    = shifted - {1'b0, divisor};
    // No borrow means the divisor fits
    assign fits    = ~diff[WIDTH];

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            quot    <= a;
            prem    <= '0;
            divisor <= b;
            b_zero  <= (b == '0);
        end else if (state == RUN) begin
            prem <= fits ? diff[WIDTH-1:0] : shifted[WIDTH-1:0];
            quot <= {quot[WIDTH-2:0], fits};
        end
    end

    assign q        = quot;
    assign r        = prem;
    assign complete = (state == DONE);

    // Unit must hold off new work while a division runs
    no_start_in_run: assert property (@(posedge clk) disable iff (rst) (state == RUN) |-> !start)
        else $error("start seen while the divider is running");

endmodule

`default_nettype wire

//--- design/div_unit.sv
/*
  Request control around the unsigned divider core.
  A reuse request takes q and r left in the core, so it must follow
  a request with identical operands and nothing in between.
*/
`timescale 1ns/100ps
`default_nettype none

module div_unit (
    input  logic              clk,
    input  logic              rst,
    input  div_pkg::div_req_t head,
    input  logic              valid,
    output logic              pop,
    output logic              start,
    output div_pkg::data_t    a,
    output div_pkg::data_t    b,
    input  div_pkg::data_t    q,
    input  div_pkg::data_t    r,
    input  logic              b_zero,
    input  logic              complete,
    output logic              done,
    output div_pkg::id_t      id,
    output div_pkg::data_t    result
);

    localparam int MSB = div_pkg::XLEN - 1;

    logic in_progress;

    // Op decode
    logic signed_op;
    logic is_rem;

    // Operand and result signs
    logic rs1_neg;
    logic rs2_neg;
    logic quot_neg;
    logic rem_neg;
    logic negate;

    div_pkg::data_t sel;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    // Reuse requests never touch the core
    assign start = valid & ~in_progress & ~head.reuse;

    // Reuse completes in its first cycle at the head
    assign done = complete | (valid & head.reuse);
    assign pop  = done;
    assign id   = head.id;

    // Blocks repeated starts for the same request
    always_ff @(posedge clk) begin
        if (rst)
            in_progress <= 1'b0;
        else if (start)
            in_progress <= 1'b1;
        else if (complete)
            in_progress <= 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // Operand conditioning
    //////////////////////////////////////////////////////////////////////

    assign signed_op = ~head.op[0];
    assign is_rem    = head.op[1];

    assign rs1_neg = signed_op & head.rs1[MSB];
    assign rs2_neg = signed_op & head.rs2[MSB];

    // Two's complement of negative signed operands
    assign a = ({div_pkg::XLEN{rs1_neg}} ^ head.rs1) + div_pkg::data_t'(rs1_neg);
    assign b = ({div_pkg::XLEN{rs2_neg}} ^ head.rs2) + div_pkg::data_t'(rs2_neg);

    //////////////////////////////////////////////////////////////////////
    // Result correction
    //////////////////////////////////////////////////////////////////////

    // Quotient sign from both operands, remainder follows the dividend
    assign quot_neg = signed_op & (head.rs1[MSB] ^ head.rs2[MSB]);
    assign rem_neg  = rs1_neg;

    // Divide by zero keeps the all ones quotient as is
    assign negate = is_rem ? rem_neg : (quot_neg & ~b_zero);
    assign sel    = is_rem ? r : q;

    // MIN / -1 lands on MIN with no negate, as RISC-V wants
    assign result = ({div_pkg::XLEN{negate}} ^ sel) + div_pkg::data_t'(negate);

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Core only finishes work the unit started
    complete_in_progress: assert property (
        @(posedge clk) disable iff (rst) complete |-> in_progress
    ) else $error("divider completed with no division in progress");

endmodule

`default_nettype wire

//--- design/div_result_bank.sv
/*
  Result store, one entry per instruction id.
  An entry is overwritten by the next completion for the same id.
  rd is combinational and valid from the cycle wb.done is high.
*/
`timescale 1ns/100ps
`default_nettype none

module div_result_bank (
    input  logic            clk,
    input  logic            rst,
    input  logic            done,
    input  div_pkg::id_t    id,
    input  div_pkg::data_t  result,
    output div_pkg::div_wb_t wb,
    input  div_pkg::id_t    wb_id,
    output div_pkg::data_t  rd
);

    localparam int ENTRIES = 2 ** div_pkg::ID_W;

    div_pkg::data_t bank [ENTRIES];

    //////////////////////////////////////////////////////////////////////
    // Store
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (done)
            bank[id] <= result;
    end

    // Writeback read port
    assign rd = bank[wb_id];

    //////////////////////////////////////////////////////////////////////
    // Done strobe
    //////////////////////////////////////////////////////////////////////

    // Strobe lags the write by one cycle, so rd is ready with it
    always_ff @(posedge clk) begin
        wb.id <= id;
        if (rst)
            wb.done <= 1'b0;
        else
            wb.done <= done;
    end

endmodule

`default_nettype wire

//--- design/div_top.sv
/*
  Divide subsystem top. Issue only while ready is high.
  Idle latency issue to wb.done is WIDTH+3 cycles, 2 for reuse.
*/
`timescale 1ns/100ps
`default_nettype none

module div_top #(
    parameter int FIFO_DEPTH = 2,
    parameter int WIDTH      = div_pkg::XLEN
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue,
    input  div_pkg::div_req_t req,
    output logic              ready,
    output div_pkg::div_wb_t  wb,
    input  div_pkg::id_t      wb_id,
    output div_pkg::data_t    rd
);

    // FIFO to unit
    div_pkg::div_req_t fifo_head;
    logic fifo_valid;
    logic fifo_full;
    logic pop;

    // Unit to core and back
    logic start;
    div_pkg::data_t core_a;
    div_pkg::data_t core_b;
    div_pkg::data_t core_q;
    div_pkg::data_t core_r;
    logic b_zero;
    logic complete;

    // Unit to bank
    logic unit_done;
    div_pkg::id_t unit_id;
    div_pkg::data_t unit_result;

    assign ready = ~fifo_full;

    div_input_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk(clk), .rst(rst), .push(issue), .data_in(req), .pop(pop),
        .data_out(fifo_head), .valid(fifo_valid), .full(fifo_full)
    );

    div_unit u_unit (
        .clk(clk), .rst(rst), .head(fifo_head), .valid(fifo_valid), .pop(pop),
        .start(start), .a(core_a), .b(core_b), .q(core_q), .r(core_r),
        .b_zero(b_zero), .complete(complete),
        .done(unit_done), .id(unit_id), .result(unit_result)
    );

    div_core #(.WIDTH(WIDTH)) u_core (
        .clk(clk), .rst(rst), .start(start), .a(core_a), .b(core_b),
        .q(core_q), .r(core_r), .b_zero(b_zero), .complete(complete)
    );

    div_result_bank u_bank (
        .clk(clk), .rst(rst), .done(unit_done), .id(unit_id), .result(unit_result),
        .wb(wb), .wb_id(wb_id), .rd(rd)
    );

endmodule

`default_nettype wire

//--- dv/div_tb.sv
/*
  Testbench for div_top with stimulus from dv/div_stim.txt, run from the project root.
  Lines of one group issue back to back and the unit drains between groups.
  The first line of each group starts on an idle unit and has its latency checked.
*/
`timescale 1ns/100ps
`default_nettype none

module div_tb;

    localparam int FIFO_DEPTH = 2;
    localparam int WIDTH      = 32;
    localparam int TIMEOUT    = 200;
    localparam int MAX_LINES  = 64;

    logic              clk;
    logic              rst;
    logic              issue;
    div_pkg::div_req_t req;
    logic              ready;
    div_pkg::div_wb_t  wb;
    div_pkg::id_t      wb_id;
    div_pkg::data_t    rd;

    // Stimulus table
    div_pkg::div_req_t reqs [MAX_LINES];
    logic [31:0] grp [MAX_LINES];
    logic [31:0] expect_val [MAX_LINES];
    int n_lines;

    // Pending holds entries in issue order
    int issue_at [MAX_LINES];
    bit lat_check [MAX_LINES];
    int pending [$];
    int cycle = 0;
    bit ready_dropped;

    div_top #(.FIFO_DEPTH(FIFO_DEPTH), .WIDTH(WIDTH)) uut (
        .clk(clk), .rst(rst), .issue(issue), .req(req), .ready(ready),
        .wb(wb), .wb_id(wb_id), .rd(rd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Edge count for latency
    always @(posedge clk) cycle <= cycle + 1;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
            stop_on_error($sformatf("Fail %s: expected %h, actual %h",
                                    name, expected, actual));
    endtask

    task automatic load_stim();
        int fd;
        int code;
        string line;
        logic [31:0] g, op, a, b, id, ru, ex;
        fd = $fopen("dv/div_stim.txt", "r");
        if (fd == 0)
            stop_on_error("could not open the stimulus file dv/div_stim.txt");
        else begin
            n_lines = 0;
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // Comment and blank lines skipped
                if (code > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h", g, op, a, b, id, ru, ex);
                    if (code != 7 || n_lines == MAX_LINES)
                        stop_on_error($sformatf("bad or excess stimulus line: %s", line));
                    else begin
                        grp[n_lines]        = g;
                        reqs[n_lines].rs1   = a;
                        reqs[n_lines].rs2   = b;
                        reqs[n_lines].op    = div_pkg::div_op_e'(op[1:0]);
                        reqs[n_lines].id    = id[1:0];
                        reqs[n_lines].reuse = ru[0];
                        expect_val[n_lines] = ex;
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Called 1 ns after a rising edge, returns at the same point of a later cycle
    task automatic issue_line(input int k);
        int waited;
        waited = 0;
        while (!ready && waited < TIMEOUT) begin
            ready_dropped = 1'b1;
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ready)
            stop_on_error("timed out waiting for ready to rise");
        else begin
            issue = 1'b1;
            req = reqs[k];
            issue_at[k] = cycle;
            pending.push_back(k);
            @(posedge clk);
            #1;
            issue = 1'b0;
        end
    endtask

    // Polls after the monitor has acted in each cycle
    task automatic drain();
        int waited;
        waited = 0;
        #2;
        while (pending.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            #3;
            waited++;
        end
        if (pending.size() != 0)
            stop_on_error("timed out waiting for outstanding results");
        else begin
            @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Writeback monitor
    //////////////////////////////////////////////////////////////////////

    initial begin : monitor
        int k;
        int exp_lat;
        forever begin
            @(posedge clk);
            #1;
            if (wb.done && pending.size() == 0)
                stop_on_error("wb.done seen with no request outstanding");
            else if (wb.done) begin
                k = pending.pop_front();
                // Reuse skips the core entirely
                exp_lat = reqs[k].reuse ? 2 : WIDTH + 3;
                wb_id = wb.id;
                check($sformatf("entry %0d id", k), 32'(reqs[k].id), 32'(wb.id));
                if (lat_check[k])
                    check($sformatf("entry %0d latency", k), exp_lat, cycle - issue_at[k]);
                // rd settles after wb_id changes
                #1;
                check($sformatf("entry %0d result", k), expect_val[k], rd);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int k;
        int first;
        rst = 1'b1;
        issue = 1'b0;
        req = '0;
        wb_id = '0;
        ready_dropped = 1'b0;
        load_stim();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check("ready after reset", 32'd1, 32'(ready));
        check("wb.done after reset", 32'd0, 32'(wb.done));
        k = 0;
        while (k < n_lines) begin
            first = k;
            lat_check[k] = 1'b1;
            ready_dropped = 1'b0;
            while (k < n_lines && grp[k] == grp[first]) begin
                issue_line(k);
                k++;
            end
            drain();
            // Burst past the FIFO depth must see back-pressure
            if (k - first > FIFO_DEPTH)
                check($sformatf("group %0d ready low", grp[first]), 32'd1, 32'(ready_dropped));
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
design/div_pkg.sv
design/div_input_fifo.sv
design/div_core.sv
design/div_unit.sv
design/div_result_bank.sv
design/div_top.sv
dv/div_tb.sv

//--- Makefile
# Verilator simulation of the divide subsystem
SIM      ?= verilator
TOP      ?= div_tb
FILELIST ?= sim.f
LOG      ?= sim.log
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, verdict taken from $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"
	@echo "Variables: SIM TOP FILELIST LOG OBJ_DIR VFLAGS"

test:
	@rm -rf $(LOG) $(OBJ_DIR)
	-$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST) > $(LOG) 2>&1
	-./$(OBJ_DIR)/V$(TOP) >> $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif ! grep -q "test passed" $(LOG); then \
		echo "no verdict found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/div_stim.txt
# group op rs1 rs2 id reuse expected, all hex; op 0 div, 1 divu, 2 rem, 3 remu
# Lines of one group issue back to back; reuse repeats the previous line's operands
0 0 00000064 00000007 0 0 0000000e
1 1 fffffffe 00000002 1 0 7fffffff
2 3 fffffffe 00000002 2 1 00000000
3 0 ffffff9c 00000007 3 0 fffffff2
3 2 ffffff9c 00000007 0 1 fffffffe
3 0 00000064 fffffff9 1 0 fffffff2
3 2 00000064 fffffff9 2 1 00000002
3 0 ffffff9c fffffff9 3 0 0000000e
3 2 ffffff9c fffffff9 0 0 fffffffe
3 3 12345678 00001000 1 0 00000678
3 1 12345678 00001000 2 1 00012345
4 0 12345678 00000000 3 0 ffffffff
4 2 12345678 00000000 0 1 12345678
4 0 ffffff9c 00000000 1 0 ffffffff
4 2 ffffff9c 00000000 2 1 ffffff9c
4 1 80000000 00000000 3 0 ffffffff
4 3 80000000 00000000 0 0 80000000
5 0 80000000 ffffffff 1 0 80000000
5 2 80000000 ffffffff 2 1 00000000
5 1 80000000 ffffffff 3 0 00000000
5 3 80000000 ffffffff 0 1 80000000
6 2 7fffffff fffffffd 1 0 00000001
6 0 7fffffff fffffffd 2 1 d5555556
6 0 fffffff9 00000002 3 0 fffffffd
6 2 fffffff9 00000002 0 1 ffffffff
7 3 0000000a 00000003 1 0 00000001
